// ==== touch_consts.svh ====
`ifndef TOUCH_CONSTS_SVH
`define TOUCH_CONSTS_SVH

// cclk cycles per touch_clk half period
`define TOUCH_CLK_DIV_COUNT 25

// Serial frame layout, in touch_clk periods
`define TOUCH_FRAME_CLOCKS 24
`define TOUCH_CMD_BITS 8
`define TOUCH_BUSY_CLOCK 8
`define TOUCH_DATA_FIRST 9
`define TOUCH_DATA_BITS 12

// Frames averaged per channel, must stay a power of two
`define TOUCH_REPETITIONS 16
`define TOUCH_REP_SHIFT 4

// Command byte fields
// Bit 7 start, 6:4 address, 3 mode (0 = 12 bit), 2 ser/dfr (0 = diff), 1:0 power
`define TOUCH_CMD_START 1'b1
`define TOUCH_ADDR_X 3'b101
`define TOUCH_ADDR_Y 3'b001
`define TOUCH_ADDR_Z 3'b011
`define TOUCH_MODE_12BIT 1'b0
`define TOUCH_REF_DIFF 1'b0
`define TOUCH_PD_BITS 2'b00

`define TOUCH_CMD_X {`TOUCH_CMD_START, `TOUCH_ADDR_X, `TOUCH_MODE_12BIT, `TOUCH_REF_DIFF, `TOUCH_PD_BITS}
`define TOUCH_CMD_Y {`TOUCH_CMD_START, `TOUCH_ADDR_Y, `TOUCH_MODE_12BIT, `TOUCH_REF_DIFF, `TOUCH_PD_BITS}
`define TOUCH_CMD_Z {`TOUCH_CMD_START, `TOUCH_ADDR_Z, `TOUCH_MODE_12BIT, `TOUCH_REF_DIFF, `TOUCH_PD_BITS}

// Panel edge margins per axis
`define TOUCH_X_ADJ_MIN 12'h096
`define TOUCH_X_POST_ADJ_MAX 12'hF6E
`define TOUCH_Y_ADJ_MIN 12'h12C
`define TOUCH_Y_POST_ADJ_MAX 12'hED8

`endif

// ==== touch_pkg.sv ====
`default_nettype none

package touch_pkg;

	// Measured channels in polling order
	typedef enum logic [1:0] {
		TOUCH_CH_X = 2'd0,
		TOUCH_CH_Y = 2'd1,
		TOUCH_CH_Z = 2'd2
	} touch_channel_e;

	function automatic touch_channel_e touch_next_channel(input touch_channel_e ch);
		case (ch)
			TOUCH_CH_X: return TOUCH_CH_Y;
			TOUCH_CH_Y: return TOUCH_CH_Z;
			default: return TOUCH_CH_X;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== touch_channel_sequencer.sv ====
`default_nettype none

`include "touch_consts.svh"

module touch_channel_sequencer
	import touch_pkg::*;
(
	input wire cclk,
	input wire rstb,
	input wire frame_done,
	input wire frame_ok,
	output logic frame_start,
	output logic [7:0] cmd_byte,
	output touch_channel_e channel
);

	localparam logic [3:0] REP_LAST = 4'(`TOUCH_REPETITIONS - 1);

	logic started;
	logic [3:0] good_count;

	// Kick off the first frame, then one frame per completion
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			started <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			started <= 1'b1;
			frame_start <= !started || frame_done;
		end
	end

	// Channel stays put until sixteen good frames are in
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			channel <= TOUCH_CH_X;
			good_count <= 4'd0;
		end else if (frame_done && frame_ok) begin
			if (good_count == REP_LAST) begin
				good_count <= 4'd0;
				channel <= touch_next_channel(channel);
			end else begin
				good_count <= good_count + 4'd1;
			end
		end
	end

	// Command for the channel being polled
	// Stable for the whole frame since channel only moves on frame_done
	always_comb begin
		case (channel)
			TOUCH_CH_X: cmd_byte = `TOUCH_CMD_X;
			TOUCH_CH_Y: cmd_byte = `TOUCH_CMD_Y;
			TOUCH_CH_Z: cmd_byte = `TOUCH_CMD_Z;
			default: cmd_byte = `TOUCH_CMD_X;
		endcase
	end

endmodule

`default_nettype wire

// ==== touch_frame_engine.sv ====
`default_nettype none

`include "touch_consts.svh"

module touch_frame_engine (
	input wire cclk,
	input wire rstb,
	input wire frame_start,
	input wire [7:0] cmd_byte,
	input wire data_in,
	input wire touch_busy,
	output logic touch_clk,
	output logic touch_csb,
	output logic data_out,
	output logic frame_done,
	output logic [11:0] sample,
	output logic frame_ok
);

	localparam logic [4:0] DIV_LAST = 5'(`TOUCH_CLK_DIV_COUNT - 1);
	localparam logic [4:0] IDX_LAST = 5'(`TOUCH_FRAME_CLOCKS - 1);
	localparam logic [4:0] CMD_LAST = 5'(`TOUCH_CMD_BITS - 1);
	localparam logic [4:0] BUSY_IDX = 5'(`TOUCH_BUSY_CLOCK);
	localparam logic [4:0] DATA_FIRST = 5'(`TOUCH_DATA_FIRST);
	localparam logic [4:0] DATA_END = 5'(`TOUCH_DATA_FIRST + `TOUCH_DATA_BITS);

	logic active;
	logic [4:0] div_count;
	logic [4:0] clk_idx;
	logic [7:0] cmd_sr;
	logic [11:0] rx_sr;
	logic busy_seen;
	logic half_done;
	logic rise_now;
	logic fall_now;

	// One touch_clk half period has elapsed
	assign half_done = active && (div_count == DIV_LAST);
	assign rise_now = half_done && !touch_clk;
	assign fall_now = half_done && touch_clk;

	// Chip select is simply held low once out of reset
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			touch_csb <= 1'b1;
		end else begin
			touch_csb <= 1'b0;
		end
	end

	// Frame control, clock divider and clock index
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			active <= 1'b0;
			div_count <= 5'd0;
			clk_idx <= 5'd0;
			touch_clk <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (!active) begin
				if (frame_start) begin
					active <= 1'b1;
					div_count <= 5'd0;
					clk_idx <= 5'd0;
				end
			end else if (half_done) begin
				div_count <= 5'd0;
				touch_clk <= !touch_clk;
				if (fall_now) begin
					if (clk_idx == IDX_LAST) begin
						active <= 1'b0;
						frame_done <= 1'b1;
					end else begin
						clk_idx <= clk_idx + 5'd1;
					end
				end
			end else begin
				div_count <= div_count + 5'd1;
			end
		end
	end

	// Command out, MSB first
	// First bit is set up at frame start, the rest move on falling edges
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			data_out <= 1'b0;
			cmd_sr <= 8'd0;
		end else if (!active && frame_start) begin
			data_out <= cmd_byte[7];
			cmd_sr <= {cmd_byte[6:0], 1'b0};
		end else if (fall_now) begin
			if (clk_idx < CMD_LAST) begin
				data_out <= cmd_sr[7];
				cmd_sr <= {cmd_sr[6:0], 1'b0};
			end else begin
				data_out <= 1'b0;
			end
		end
	end

	// Busy check on rising edge of clock 8
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			busy_seen <= 1'b0;
		end else if (!active && frame_start) begin
			busy_seen <= 1'b0;
		end else if (rise_now && clk_idx == BUSY_IDX) begin
			busy_seen <= touch_busy;
		end
	end

	// Result bits arrive MSB first on rising edges of clocks 9 to 20
	always_ff @(posedge cclk) begin
		if (rise_now && clk_idx >= DATA_FIRST && clk_idx < DATA_END) begin
			rx_sr <= {rx_sr[10:0], data_in};
		end
	end

	// Result registers, loaded with the done strobe
	always_ff @(posedge cclk) begin
		if (fall_now && clk_idx == IDX_LAST) begin
			sample <= rx_sr;
			frame_ok <= busy_seen;
		end
	end

endmodule

`default_nettype wire

// ==== touch_result_averager.sv ====
`default_nettype none

`include "touch_consts.svh"

module touch_result_averager
	import touch_pkg::*;
(
	input wire cclk,
	input wire rstb,
	input wire frame_done,
	input wire frame_ok,
	input wire [11:0] sample,
	input touch_channel_e channel,
	output logic [11:0] x,
	output logic [11:0] y,
	output logic [11:0] z,
	output logic update,
	output logic [7:0] fault_count
);

	localparam logic [3:0] REP_LAST = 4'(`TOUCH_REPETITIONS - 1);

	logic [15:0] acc;
	logic [3:0] good_count;
	logic [15:0] sum_next;
	logic [15:0] avg_wide;
	logic [11:0] avg;

	// Sixteen 12-bit samples fit in 16 bits without overflow
	assign sum_next = acc + {4'd0, sample};
	assign avg_wide = sum_next >> `TOUCH_REP_SHIFT;
	assign avg = avg_wide[11:0];

	// Remove the edge margin, then cap at the axis ceiling
	function automatic logic [11:0] calibrate(
		input logic [11:0] raw,
		input logic [11:0] adj_min,
		input logic [11:0] post_max
	);
		logic [11:0] adj;
		adj = (raw < adj_min) ? 12'd0 : raw - adj_min;
		return (adj > post_max) ? post_max : adj;
	endfunction

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			acc <= 16'd0;
			good_count <= 4'd0;
			x <= 12'd0;
			y <= 12'd0;
			z <= 12'd0;
			update <= 1'b0;
			fault_count <= 8'd0;
		end else begin
			update <= 1'b0;
			if (frame_done && frame_ok) begin
				if (good_count == REP_LAST) begin
					acc <= 16'd0;
					good_count <= 4'd0;
					update <= 1'b1;
					case (channel)
						TOUCH_CH_X: x <= calibrate(avg, `TOUCH_X_ADJ_MIN, `TOUCH_X_POST_ADJ_MAX);
						TOUCH_CH_Y: y <= calibrate(avg, `TOUCH_Y_ADJ_MIN, `TOUCH_Y_POST_ADJ_MAX);
						default: z <= avg;
					endcase
				end else begin
					acc <= sum_next;
					good_count <= good_count + 4'd1;
				end
			end else if (frame_done) begin
				// Missing busy, sample dropped
				if (fault_count != 8'hFF) begin
					fault_count <= fault_count + 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== touchpad_controller.sv ====
`default_nettype none

module touchpad_controller
	import touch_pkg::*;
(
	input wire cclk,
	input wire rstb,
	input wire touch_busy,
	input wire data_in,
	output wire touch_clk,
	output wire touch_csb,
	output wire data_out,
	output wire [11:0] x,
	output wire [11:0] y,
	output wire [11:0] z,
	output wire update,
	output wire [7:0] fault_count
);

	wire frame_start;
	wire [7:0] cmd_byte;
	wire frame_done;
	wire frame_ok;
	wire [11:0] sample;
	touch_channel_e channel;

	// Channel order and command bytes
	touch_channel_sequencer u_sequencer (
		.cclk(cclk),
		.rstb(rstb),
		.frame_done(frame_done),
		.frame_ok(frame_ok),
		.frame_start(frame_start),
		.cmd_byte(cmd_byte),
		.channel(channel)
	);

	// Serial frames on the panel pins
	touch_frame_engine u_engine (
		.cclk(cclk),
		.rstb(rstb),
		.frame_start(frame_start),
		.cmd_byte(cmd_byte),
		.data_in(data_in),
		.touch_busy(touch_busy),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.frame_done(frame_done),
		.sample(sample),
		.frame_ok(frame_ok)
	);

	touch_result_averager u_averager (
		.cclk(cclk),
		.rstb(rstb),
		.frame_done(frame_done),
		.frame_ok(frame_ok),
		.sample(sample),
		.channel(channel),
		.x(x),
		.y(y),
		.z(z),
		.update(update),
		.fault_count(fault_count)
	);

endmodule

`default_nettype wire

// ==== touch_panel_model.sv ====
`default_nettype none

`include "touch_consts.svh"

module touch_panel_model
	import touch_pkg::*;
(
	input wire touch_clk,
	input wire touch_csb,
	input wire data_out,
	input logic [11:0] script_x [16],
	input logic [11:0] script_y [16],
	input logic [11:0] script_z [16],
	input wire drop_busy,
	input wire [3:0] drop_index,
	output wire touch_busy,
	output wire data_in,
	output int frame_count,
	output int cmd_mismatches
);
	timeunit 1ns;
	timeprecision 1ps;

	logic busy_q = 1'b0;
	logic data_q = 1'b0;
	logic [4:0] clk_count = 5'd0;
	logic [4:0] cur_idx = 5'd0;
	logic [7:0] cmd_sr = 8'd0;
	logic [11:0] tx_word = 12'd0;
	logic [11:0] shift_sr = 12'd0;
	logic give_busy = 1'b1;
	logic drop_used = 1'b0;
	logic [3:0] idx_x = 4'd0;
	logic [3:0] idx_y = 4'd0;
	logic [3:0] idx_z = 4'd0;
	logic [3:0] expect_good = 4'd0;
	touch_channel_e expect_ch = TOUCH_CH_X;
	int frames = 0;
	int mismatches = 0;

	assign touch_busy = busy_q;
	assign data_in = data_q;
	assign frame_count = frames;
	assign cmd_mismatches = mismatches;

	function automatic logic [7:0] expected_command(input touch_channel_e ch);
		case (ch)
			TOUCH_CH_Y: return `TOUCH_CMD_Y;
			TOUCH_CH_Z: return `TOUCH_CMD_Z;
			default: return `TOUCH_CMD_X;
		endcase
	endfunction

	function automatic touch_channel_e following_channel(input touch_channel_e ch);
		case (ch)
			TOUCH_CH_X: return TOUCH_CH_Y;
			TOUCH_CH_Y: return TOUCH_CH_Z;
			default: return TOUCH_CH_X;
		endcase
	endfunction

	// Command capture, channel decode and sample pick on rising edges
	always @(posedge touch_clk) begin : rise_edge
		touch_channel_e ch;
		logic [11:0] word;
		if (!touch_csb) begin
			cur_idx = clk_count;
			if (cur_idx < 5'd8) begin
				cmd_sr = {cmd_sr[6:0], data_out};
			end
			if (cur_idx == 5'd7) begin
				if (cmd_sr != expected_command(expect_ch)) begin
					mismatches++;
					$display("[ERROR] %0t data_out command expected %02h got %02h",
						$time, expected_command(expect_ch), cmd_sr);
				end
				case (cmd_sr[6:4])
					`TOUCH_ADDR_Y: begin
						ch = TOUCH_CH_Y;
						word = script_y[idx_y];
					end
					`TOUCH_ADDR_Z: begin
						ch = TOUCH_CH_Z;
						word = script_z[idx_z];
					end
					default: begin
						ch = TOUCH_CH_X;
						word = script_x[idx_x];
					end
				endcase
				give_busy = !(drop_busy && !drop_used && ch == TOUCH_CH_X && idx_x == drop_index);
				if (give_busy) begin
					tx_word = word;
					if (ch == TOUCH_CH_X) idx_x = idx_x + 4'd1;
					if (ch == TOUCH_CH_Y) idx_y = idx_y + 4'd1;
					if (ch == TOUCH_CH_Z) idx_z = idx_z + 4'd1;
				end else begin
					// Garbage word so a counted drop would show in the average
					tx_word = 12'hFFF;
					drop_used = 1'b1;
				end
			end
			if (cur_idx == 5'd23) begin
				frames++;
				clk_count = 5'd0;
				if (give_busy) begin
					if (expect_good == 4'd15) begin
						expect_ch = following_channel(expect_ch);
					end
					expect_good = expect_good + 4'd1;
				end
			end else begin
				clk_count = clk_count + 5'd1;
			end
			if (!drop_busy) begin
				drop_used = 1'b0;
			end
		end
	end

	// Busy for clock 8, then the result MSB first
	always @(negedge touch_clk) begin
		if (!touch_csb) begin
			busy_q <= (cur_idx == 5'd7) && give_busy;
			if (cur_idx == 5'd7) begin
				shift_sr = tx_word;
				data_q <= 1'b0;
			end else if (cur_idx >= 5'd8 && cur_idx < 5'd20) begin
				data_q <= shift_sr[11];
				shift_sr = {shift_sr[10:0], 1'b0};
			end else begin
				data_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== touchpad_tb.sv ====
`default_nettype none

`include "touch_consts.svh"

module touchpad_tb
	import touch_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// Five full X/Y/Z rounds
	localparam int TIMEOUT_CYCLES = 5 * 3 * `TOUCH_REPETITIONS * 1201;
	localparam int MIN_FRAMES = 3 * 3 * `TOUCH_REPETITIONS + `TOUCH_REPETITIONS + 1;

	logic cclk;
	logic rstb;
	wire touch_busy;
	wire data_in;
	wire touch_clk;
	wire touch_csb;
	wire data_out;
	wire [11:0] x;
	wire [11:0] y;
	wire [11:0] z;
	wire update;
	wire [7:0] fault_count;

	logic [11:0] script_x [16];
	logic [11:0] script_y [16];
	logic [11:0] script_z [16];
	logic [11:0] next_x [16];
	logic [11:0] next_y [16];
	logic [11:0] next_z [16];
	logic drop_busy;
	logic [3:0] drop_index;
	int frame_count;
	int cmd_mismatches;

	logic [11:0] exp_x;
	logic [11:0] exp_y;
	logic [11:0] exp_z;
	logic [7:0] exp_faults;
	int value_errors;
	int other_errors;
	int cycle_count = 0;

	touchpad_controller UUT (
		.cclk(cclk),
		.rstb(rstb),
		.touch_busy(touch_busy),
		.data_in(data_in),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.x(x),
		.y(y),
		.z(z),
		.update(update),
		.fault_count(fault_count)
	);

	touch_panel_model panel (
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.script_x(script_x),
		.script_y(script_y),
		.script_z(script_z),
		.drop_busy(drop_busy),
		.drop_index(drop_index),
		.touch_busy(touch_busy),
		.data_in(data_in),
		.frame_count(frame_count),
		.cmd_mismatches(cmd_mismatches)
	);

	initial begin
		cclk = 1'b0;
		forever #5 cclk = ~cclk;
	end

	always @(posedge cclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles while waiting for an update strobe", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [11:0] expected,
		input logic [11:0] actual);
		value_errors++;
		$display("[ERROR] %0t %s expected 0x%03h got 0x%03h", $time, name, expected, actual);
	endtask

	// Mean of sixteen samples, less the margin with a floor of zero, capped at the ceiling
	function automatic logic [11:0] calibrated_mean(input logic [11:0] samples [16],
		input logic [11:0] margin, input logic [11:0] ceiling);
		int sum;
		int mean;
		sum = 0;
		foreach (samples[i]) sum = sum + int'(samples[i]);
		mean = sum / `TOUCH_REPETITIONS;
		if (mean < int'(margin)) mean = 0;
		else mean = mean - int'(margin);
		if (mean > int'(ceiling)) mean = int'(ceiling);
		return 12'(mean);
	endfunction

	task automatic wait_update();
		do @(posedge cclk); while (update !== 1'b1);
	endtask

	task automatic check_outputs();
		if (x !== exp_x) report_mismatch("x", exp_x, x);
		if (y !== exp_y) report_mismatch("y", exp_y, y);
		if (z !== exp_z) report_mismatch("z", exp_z, z);
		if (fault_count !== exp_faults) begin
			report_mismatch("fault_count", {4'd0, exp_faults}, {4'd0, fault_count});
		end
	endtask

	task automatic check_reset_values();
		check_outputs();
		if (update !== 1'b0) report_mismatch("update", 12'd0, {11'd0, update});
		if (touch_clk !== 1'b0) report_mismatch("touch_clk", 12'd0, {11'd0, touch_clk});
		if (data_out !== 1'b0) report_mismatch("data_out", 12'd0, {11'd0, data_out});
	endtask

	task automatic apply_scripts();
		@(posedge cclk);
		foreach (script_x[i]) begin
			script_x[i] <= next_x[i];
			script_y[i] <= next_y[i];
			script_z[i] <= next_z[i];
		end
	endtask

	// One X, Y, Z round; each update must touch only its own channel
	task automatic check_round();
		exp_x = calibrated_mean(next_x, `TOUCH_X_ADJ_MIN, `TOUCH_X_POST_ADJ_MAX);
		wait_update();
		check_outputs();
		exp_y = calibrated_mean(next_y, `TOUCH_Y_ADJ_MIN, `TOUCH_Y_POST_ADJ_MAX);
		wait_update();
		check_outputs();
		exp_z = calibrated_mean(next_z, 12'd0, 12'hFFF);
		wait_update();
		check_outputs();
	endtask

	task automatic run_constant_test();
		foreach (next_x[i]) begin
			next_x[i] = 12'h800;
			next_y[i] = 12'h640;
			next_z[i] = 12'h3A5;
		end
		apply_scripts();
		check_round();
	endtask

	task automatic run_random_test();
		foreach (next_x[i]) begin
			next_x[i] = 12'($urandom);
			next_y[i] = 12'($urandom);
			next_z[i] = 12'($urandom);
		end
		apply_scripts();
		check_round();
	endtask

	task automatic run_clamp_test();
		foreach (next_x[i]) begin
			next_x[i] = 12'($urandom % 32'h096);
			next_y[i] = 12'hFFF;
			next_z[i] = 12'($urandom);
		end
		apply_scripts();
		check_round();
	endtask

	task automatic run_busy_fault_test();
		foreach (next_x[i]) begin
			next_x[i] = 12'($urandom);
			next_y[i] = 12'($urandom);
			next_z[i] = 12'($urandom);
		end
		apply_scripts();
		drop_busy <= 1'b1;
		drop_index <= 4'($urandom % 16);
		exp_faults = exp_faults + 8'd1;
		exp_x = calibrated_mean(next_x, `TOUCH_X_ADJ_MIN, `TOUCH_X_POST_ADJ_MAX);
		wait_update();
		check_outputs();
		@(posedge cclk);
		drop_busy <= 1'b0;
	endtask

	task automatic check_pin_protocol();
		if (touch_csb !== 1'b0) begin
			other_errors++;
			$display("Chip select touch_csb was not held low after reset");
		end
		if (frame_count < MIN_FRAMES) begin
			other_errors++;
			$display("Panel saw only %0d frames, at least %0d expected", frame_count, MIN_FRAMES);
		end
		value_errors = value_errors + cmd_mismatches;
	endtask

	initial begin
		void'($urandom(87));
		rstb = 1'b0;
		drop_busy = 1'b0;
		drop_index = 4'd0;
		foreach (script_x[i]) begin
			script_x[i] = 12'd0;
			script_y[i] = 12'd0;
			script_z[i] = 12'd0;
		end
		exp_x = 12'd0;
		exp_y = 12'd0;
		exp_z = 12'd0;
		exp_faults = 8'd0;
		value_errors = 0;
		other_errors = 0;
		repeat (8) @(posedge cclk);
		check_reset_values();
		rstb <= 1'b1;
		run_constant_test();
		run_random_test();
		run_clamp_test();
		run_busy_fault_test();
		check_pin_protocol();
		$display("Error counts: value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
touch_pkg.sv
touch_channel_sequencer.sv
touch_frame_engine.sv
touch_result_averager.sv
touchpad_controller.sv
touch_panel_model.sv
touchpad_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the touch panel controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module touchpad_tb \
	-f filelist.f \
	-o touchpad_sim

./obj_dir/touchpad_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
	echo "Simulation run passed"
	exit 0
fi
echo "Simulation run failed, see sim.log"
exit 1
